// File: logic/csr_pkg.sv
package csr_pkg;

    localparam int xlen = 64;

    // Machine-mode CSR addresses handled by the block.
    localparam logic [11:0] csr_addr_mstatus = 12'h300;
    localparam logic [11:0] csr_addr_mtvec   = 12'h305;
    localparam logic [11:0] csr_addr_mepc    = 12'h341;
    localparam logic [11:0] csr_addr_mcause  = 12'h342;

    localparam logic [xlen-1:0] mstatus_reset = 64'h0000_0000_a000_1800;

    localparam logic [xlen-1:0] cause_illegal = 64'd2;
    localparam logic [xlen-1:0] cause_ecall_m = 64'd11;

    // Instruction encodings.
    localparam logic [6:0]  opcode_system = 7'b111_0011;
    localparam logic [31:0] instr_ecall   = 32'h0000_0073;
    localparam logic [31:0] instr_mret    = 32'h3020_0073;

    localparam int mstatus_mie  = 3;  // Global interrupt enable.
    localparam int mstatus_mpie = 7;  // Previous interrupt enable.

    localparam int cmd_fifo_depth = 4;

    typedef enum logic [1:0] {
        op_write,
        op_set,
        op_clear
    } csr_op_e;

    typedef enum logic [1:0] {
        kind_csr,
        kind_ecall,
        kind_mret,
        kind_illegal
    } cmd_kind_e;

    // One decoded SYSTEM instruction on its way to the CSR file.
    typedef struct packed {
        cmd_kind_e        kind;
        csr_op_e          op;
        logic [11:0]      csr_addr;
        logic             write_en;
        logic [xlen-1:0]  source;
        logic [xlen-1:0]  pc;
    } csr_cmd_t;

endpackage

// File: logic/csr_fifo.sv
`timescale 1ns/1ns

module csr_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    payload_t mem [depth];

    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic [$clog2(depth):0]   count;

    assign full     = (count == depth);
    assign empty    = (count == 0);
    assign pop_data = mem[rd_ptr];  // Head is visible without a read strobe.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) full |-> !push)
        else $error("push into a full FIFO");
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) empty |-> !pop)
        else $error("pop from an empty FIFO");

endmodule

// File: logic/csr_decoder.sv
`timescale 1ns/1ns

module csr_decoder (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [31:0]              wb_dat_w,
    input  logic [csr_pkg::xlen-1:0] wb_rs1,
    input  logic [csr_pkg::xlen-1:0] wb_pc,
    output logic                     wb_ack,
    input  logic                     full,
    output logic                     push,
    output csr_pkg::csr_cmd_t        push_data
);
    import csr_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs1_field;
    logic       accept;
    logic       accepted;
    csr_cmd_t   cmd;

    assign opcode    = wb_dat_w[6:0];
    assign funct3    = wb_dat_w[14:12];
    assign rs1_field = wb_dat_w[19:15];

    // The request is still held during the ack cycle, so it must not be taken twice.
    assign accept = wb_cyc && wb_stb && wb_we && !full && !accepted;

    always_comb begin
        cmd          = '0;
        cmd.kind     = kind_illegal;
        cmd.op       = op_write;
        cmd.write_en = 1'b0;
        cmd.csr_addr = wb_dat_w[31:20];
        cmd.pc       = wb_pc;
        // Immediate forms carry a zero-extended zimm in the rs1 field.
        cmd.source   = funct3[2] ? {{(xlen - 5){1'b0}}, rs1_field} : wb_rs1;
        if (opcode == opcode_system) begin
            case (funct3)
                3'b001, 3'b101: begin
                    cmd.kind     = kind_csr;
                    cmd.op       = op_write;
                    cmd.write_en = 1'b1;
                end
                3'b010, 3'b110: begin
                    cmd.kind     = kind_csr;
                    cmd.op       = op_set;
                    cmd.write_en = (rs1_field != 5'd0);
                end
                3'b011, 3'b111: begin
                    cmd.kind     = kind_csr;
                    cmd.op       = op_clear;
                    cmd.write_en = (rs1_field != 5'd0);
                end
                3'b000: begin
                    if (wb_dat_w == instr_ecall) begin
                        cmd.kind = kind_ecall;
                    end else if (wb_dat_w == instr_mret) begin
                        cmd.kind = kind_mret;
                    end
                end
                default: begin
                    cmd.kind = kind_illegal;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            accepted <= 1'b0;
        end else begin
            accepted <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_data <= cmd;
        end
    end

    assign wb_ack = accepted;
    assign push   = accepted;  // The entry enters the FIFO in the ack cycle.

    a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack held high for two cycles");

endmodule

// File: logic/csr_file.sv
`timescale 1ns/1ns

module csr_file (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     empty,
    input  csr_pkg::csr_cmd_t        pop_data,
    output logic                     pop,
    output logic                     res_cyc,
    output logic                     res_stb,
    output logic                     res_we,
    output logic [csr_pkg::xlen-1:0] res_dat,
    output logic                     res_redirect,
    output logic [csr_pkg::xlen-1:0] res_target,
    input  logic                     res_ack
);
    import csr_pkg::*;

    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;

    logic            busy;
    logic            start;
    logic            addr_known;
    logic            take_trap;
    logic            is_mret;
    logic [xlen-1:0] old_value;
    logic [xlen-1:0] new_value;
    logic [xlen-1:0] trap_cause;
    logic [xlen-1:0] trap_mstatus;
    logic [xlen-1:0] mret_mstatus;

    // A new command starts only once the previous result has been taken.
    assign start = !busy && !empty;

    always_comb begin
        addr_known = 1'b1;
        case (pop_data.csr_addr)
            csr_addr_mstatus: old_value = mstatus;
            csr_addr_mtvec:   old_value = mtvec;
            csr_addr_mepc:    old_value = mepc;
            csr_addr_mcause:  old_value = mcause;
            default: begin
                old_value  = '0;
                addr_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (pop_data.op)
            op_set:   new_value = old_value | pop_data.source;
            op_clear: new_value = old_value & ~pop_data.source;
            default:  new_value = pop_data.source;
        endcase
    end

    assign is_mret   = (pop_data.kind == kind_mret);
    assign take_trap = (pop_data.kind == kind_illegal) ||
                       (pop_data.kind == kind_ecall) ||
                       (pop_data.kind == kind_csr && !addr_known);
    assign trap_cause = (pop_data.kind == kind_ecall) ? cause_ecall_m : cause_illegal;

    // Trap entry saves MIE in MPIE and records machine mode in MPP.
    always_comb begin
        trap_mstatus               = mstatus;
        trap_mstatus[mstatus_mpie] = mstatus[mstatus_mie];
        trap_mstatus[mstatus_mie]  = 1'b0;
        trap_mstatus[12:11]        = 2'b11;
    end

    always_comb begin
        mret_mstatus               = mstatus;
        mret_mstatus[mstatus_mie]  = mstatus[mstatus_mpie];
        mret_mstatus[mstatus_mpie] = 1'b1;
        mret_mstatus[12:11]        = 2'b00;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (busy && res_ack) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= mstatus_reset;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (start) begin
            if (take_trap) begin
                mepc    <= pop_data.pc;
                mcause  <= trap_cause;
                mstatus <= trap_mstatus;
            end else if (is_mret) begin
                mstatus <= mret_mstatus;
            end else if (pop_data.write_en) begin
                case (pop_data.csr_addr)
                    csr_addr_mstatus: mstatus <= new_value;
                    csr_addr_mtvec:   mtvec   <= new_value;
                    csr_addr_mepc:    mepc    <= new_value;
                    csr_addr_mcause:  mcause  <= new_value;
                    default:          mstatus <= mstatus;
                endcase
            end
        end
    end

    // The result is captured together with the CSR update.
    always_ff @(posedge clk) begin
        if (start) begin
            if (take_trap) begin
                res_dat      <= '0;
                res_redirect <= 1'b1;
                res_target   <= mtvec;
            end else if (is_mret) begin
                res_dat      <= '0;
                res_redirect <= 1'b1;
                res_target   <= mepc;
            end else begin
                res_dat      <= old_value;
                res_redirect <= 1'b0;
                res_target   <= '0;
            end
        end
    end

    assign res_cyc = busy;
    assign res_stb = busy;
    assign res_we  = busy;
    assign pop     = busy && res_ack;  // Head leaves the FIFO as the transfer ends.

    a_res_stable: assert property (@(posedge clk) disable iff (rst)
        res_stb && !res_ack |=> res_stb && $stable(res_dat) && $stable(res_redirect)
                                && $stable(res_target))
        else $error("result changed before res_ack");

endmodule

// File: logic/csr_unit_top.sv
`timescale 1ns/1ns

module csr_unit_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [31:0]              wb_dat_w,
    input  logic [csr_pkg::xlen-1:0] wb_rs1,
    input  logic [csr_pkg::xlen-1:0] wb_pc,
    output logic                     wb_ack,
    output logic                     res_cyc,
    output logic                     res_stb,
    output logic                     res_we,
    output logic [csr_pkg::xlen-1:0] res_dat,
    output logic                     res_redirect,
    output logic [csr_pkg::xlen-1:0] res_target,
    input  logic                     res_ack
);
    import csr_pkg::*;

    logic     push;
    logic     full;
    logic     pop;
    logic     empty;
    csr_cmd_t push_data;
    csr_cmd_t pop_data;

    csr_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_dat_w  (wb_dat_w),
        .wb_rs1    (wb_rs1),
        .wb_pc     (wb_pc),
        .wb_ack    (wb_ack),
        .full      (full),
        .push      (push),
        .push_data (push_data)
    );

    csr_fifo #(
        .payload_t (csr_cmd_t),
        .depth     (cmd_fifo_depth)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty)
    );

    csr_file u_file (
        .clk          (clk),
        .rst          (rst),
        .empty        (empty),
        .pop_data     (pop_data),
        .pop          (pop),
        .res_cyc      (res_cyc),
        .res_stb      (res_stb),
        .res_we       (res_we),
        .res_dat      (res_dat),
        .res_redirect (res_redirect),
        .res_target   (res_target),
        .res_ack      (res_ack)
    );

endmodule

// File: verification/csr_checker.sv
`timescale 1ns/1ns

module csr_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_ack,
    input  logic                     res_cyc,
    input  logic                     res_stb,
    input  logic                     res_we,
    input  logic                     res_ack,
    input  logic [csr_pkg::xlen-1:0] res_dat,
    input  logic                     res_redirect,
    input  logic [csr_pkg::xlen-1:0] res_target,
    input  logic [8*16-1:0]          exp_name,
    input  logic [csr_pkg::xlen-1:0] exp_dat,
    input  logic                     exp_redirect,
    input  logic [csr_pkg::xlen-1:0] exp_target,
    output int                       out_count,
    output int                       pass_count,
    output int                       error_count,
    output logic                     input_stalled
);

    int in_count;
    int wait_cycles;

    // A request normally waits one edge for its ack. Two or more means back-pressure.
    always @(posedge clk) begin
        if (rst) begin
            wait_cycles   <= 0;
            input_stalled <= 1'b0;
        end else if (wb_cyc && wb_stb && !wb_ack) begin
            wait_cycles <= wait_cycles + 1;
            if (wait_cycles >= 1) begin
                input_stalled <= 1'b1;
            end
        end else begin
            wait_cycles <= 0;
        end
    end

    // The n-th accepted instruction owns the n-th result. The expected
    // values for result out_count are presented on the exp_* ports.
    always @(posedge clk) begin
        if (rst) begin
            in_count    <= 0;
            out_count   <= 0;
            pass_count  <= 0;
            error_count <= 0;
        end else begin
            if (wb_cyc && wb_stb && wb_ack) begin
                in_count <= in_count + 1;
            end
            if (res_cyc && res_stb && res_ack) begin
                out_count <= out_count + 1;
                if (out_count >= in_count) begin
                    $display("Result %0d came out with no accepted instruction behind it",
                             out_count);
                    error_count <= error_count + 1;
                end else if (res_dat !== exp_dat || res_redirect !== exp_redirect ||
                             res_target !== exp_target || res_we !== 1'b1) begin
                    $display("ERR %0s: expected dat=%h redirect=%b target=%h we=1,",
                             exp_name, exp_dat, exp_redirect, exp_target,
                             " actual dat=%h redirect=%b target=%h we=%b",
                             res_dat, res_redirect, res_target, res_we);
                    error_count <= error_count + 1;
                end else begin
                    $display("ok  %0s: dat=%h redirect=%b target=%h",
                             exp_name, res_dat, res_redirect, res_target);
                    pass_count <= pass_count + 1;
                end
            end
        end
    end

endmodule

// File: verification/csr_tb.sv
`timescale 1ns/1ns

module csr_tb;

    typedef struct packed {
        logic [8*16-1:0] name;
        logic [31:0]     instr;
        logic [63:0]     rs1;
        logic [63:0]     pc;
        logic [63:0]     dat;
        logic            redirect;
        logic [63:0]     target;
    } test_t;

    localparam int num_tests      = 29;
    localparam int burst_start    = 22;  // First entry of the back-pressure burst.
    localparam int timeout_cycles = 40 * num_tests + 50;

    // Expected values follow the CSR state left behind by the entries above them.
    localparam test_t tests [num_tests] = '{
        '{"rd_mstatus",      32'h300020f3, 64'hff,       64'h1000,     64'ha000_1800, 1'b0, 64'h0},
        '{"wr_mtvec",        32'h305290f3, 64'h8000_0100, 64'h1004,    64'h0,         1'b0, 64'h0},
        '{"set_mtvec",       32'h3052a0f3, 64'h30,       64'h1008,     64'h8000_0100, 1'b0, 64'h0},
        '{"clri_mtvec",      32'h305870f3, 64'hffff_ffff, 64'h100c,    64'h8000_0130, 1'b0, 64'h0},
        '{"rd_mtvec",        32'h305020f3, 64'h0,        64'h1010,     64'h8000_0120, 1'b0, 64'h0},
        '{"wri_mepc",        32'h341e50f3, 64'h0,        64'h1014,     64'h0,         1'b0, 64'h0},
        '{"seti_mepc_zero",  32'h341060f3, 64'hff,       64'h1018,     64'h1c,        1'b0, 64'h0},
        '{"clr_mepc",        32'h3412b0f3, 64'hc,        64'h101c,     64'h1c,        1'b0, 64'h0},
        '{"seti_mepc",       32'h3411e0f3, 64'h0,        64'h1020,     64'h10,        1'b0, 64'h0},
        '{"rd_mepc",         32'h341020f3, 64'h0,        64'h1024,     64'h13,        1'b0, 64'h0},
        '{"seti_mstatus",    32'h300460f3, 64'h0,        64'h1028,     64'ha000_1800, 1'b0, 64'h0},
        '{"ecall",           32'h00000073, 64'h0,        64'h2000,     64'h0, 1'b1, 64'h8000_0120},
        '{"rd_mepc_trap",    32'h341020f3, 64'h0,        64'h8000_0120, 64'h2000,     1'b0, 64'h0},
        '{"rd_mcause",       32'h342020f3, 64'h0,        64'h8000_0124, 64'hb,        1'b0, 64'h0},
        '{"rd_mstatus_trap", 32'h300020f3, 64'h0,        64'h8000_0128, 64'ha000_1880, 1'b0, 64'h0},
        '{"wr_mepc",         32'h341290f3, 64'h2004,     64'h8000_012c, 64'h2000,     1'b0, 64'h0},
        '{"mret",            32'h30200073, 64'h0,        64'h8000_0130, 64'h0, 1'b1, 64'h2004},
        '{"rd_mstatus_mret", 32'h300020f3, 64'h0,        64'h2004,     64'ha000_0088, 1'b0, 64'h0},
        '{"csr_unknown",     32'h7c0020f3, 64'h0,        64'h4000,     64'h0, 1'b1, 64'h8000_0120},
        '{"rd_mcause_ill",   32'h342020f3, 64'h0,        64'h8000_0120, 64'h2,        1'b0, 64'h0},
        '{"bad_system",      32'h00004073, 64'h0,        64'h5000,     64'h0, 1'b1, 64'h8000_0120},
        '{"rd_mepc_ill",     32'h341020f3, 64'h0,        64'h8000_0124, 64'h5000,     1'b0, 64'h0},
        '{"burst_0",         32'h341290f3, 64'h100,      64'h6000,     64'h5000,      1'b0, 64'h0},
        '{"burst_1",         32'h341290f3, 64'h200,      64'h6004,     64'h100,       1'b0, 64'h0},
        '{"burst_2",         32'h341290f3, 64'h300,      64'h6008,     64'h200,       1'b0, 64'h0},
        '{"burst_3",         32'h341290f3, 64'h400,      64'h600c,     64'h300,       1'b0, 64'h0},
        '{"burst_4",         32'h341290f3, 64'h500,      64'h6010,     64'h400,       1'b0, 64'h0},
        '{"burst_5",         32'h341290f3, 64'h600,      64'h6014,     64'h500,       1'b0, 64'h0},
        '{"burst_rd",        32'h341020f3, 64'h0,        64'h6018,     64'h600,       1'b0, 64'h0}
    };

    logic        clk = 1'b0;
    logic        rst;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [31:0] wb_dat_w;
    logic [63:0] wb_rs1, wb_pc;
    logic        res_cyc, res_stb, res_we, res_redirect, res_ack;
    logic [63:0] res_dat, res_target;
    logic [31:0] lfsr_state = 32'hf9fb_e2f0;
    logic        input_stalled;
    int          cycle_count = 0;
    int          stall_end = 0;
    int          out_count, pass_count, error_count, exp_idx;

    always #4 clk = ~clk;

    csr_unit_top uut (
        .clk (clk), .rst (rst),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_dat_w (wb_dat_w),
        .wb_rs1 (wb_rs1), .wb_pc (wb_pc), .wb_ack (wb_ack),
        .res_cyc (res_cyc), .res_stb (res_stb), .res_we (res_we), .res_dat (res_dat),
        .res_redirect (res_redirect), .res_target (res_target), .res_ack (res_ack)
    );

    assign exp_idx = (out_count < num_tests) ? out_count : 0;

    csr_checker u_check (
        .clk (clk), .rst (rst),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_ack (wb_ack),
        .res_cyc (res_cyc), .res_stb (res_stb), .res_we (res_we), .res_ack (res_ack),
        .res_dat (res_dat), .res_redirect (res_redirect), .res_target (res_target),
        .exp_name (tests[exp_idx].name), .exp_dat (tests[exp_idx].dat),
        .exp_redirect (tests[exp_idx].redirect), .exp_target (tests[exp_idx].target),
        .out_count (out_count), .pass_count (pass_count), .error_count (error_count),
        .input_stalled (input_stalled)
    );

    // Fibonacci LFSR with taps 32, 22, 2, 1.
    function automatic logic next_random_bit();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    // Called on a rising edge. Returns on the edge that closes the ack cycle.
    task automatic write_instruction(input int idx);
        #1;
        if (idx == burst_start) begin
            stall_end = cycle_count + 12;  // Long enough to fill the FIFO.
        end
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_dat_w = tests[idx].instr;
        wb_rs1   = tests[idx].rs1;
        wb_pc    = tests[idx].pc;
        @(posedge clk);
        while (!wb_ack) @(posedge clk);
    endtask

    always @(posedge clk) begin
        logic hold;
        logic bit_a;
        logic bit_b;
        hold = (cycle_count < stall_end);
        #1;
        bit_a   = next_random_bit();
        bit_b   = next_random_bit();
        res_ack = !(bit_a && bit_b) && !hold;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("Timeout after %0d cycles with %0d of %0d results seen",
                     cycle_count, out_count, num_tests);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_dat_w = '0;
        wb_rs1   = '0;
        wb_pc    = '0;
        res_ack  = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        for (int i = 0; i < num_tests; i++) begin
            write_instruction(i);
        end
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        while (out_count < num_tests) @(posedge clk);
        repeat (4) @(posedge clk);  // Catch any stray result.
        if (!input_stalled) begin
            $display("The input never saw a delayed ack while the output was stalled");
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, error_count);
        if (error_count == 0 && pass_count == num_tests && input_stalled) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/csr_pkg.sv
logic/csr_fifo.sv
logic/csr_decoder.sv
logic/csr_file.sv
logic/csr_unit_top.sv
verification/csr_checker.sv
verification/csr_tb.sv

// File: Bender.yml
package:
  name: csr_unit

sources:
  - logic/csr_pkg.sv
  - logic/csr_fifo.sv
  - logic/csr_decoder.sv
  - logic/csr_file.sv
  - logic/csr_unit_top.sv
  - target: test
    files:
      - verification/csr_checker.sv
      - verification/csr_tb.sv
